// ==== common/snake_settings.svh ====
`ifndef SNAKE_SETTINGS_SVH
`define SNAKE_SETTINGS_SVH

// Last legal coordinate on each axis
`define SNAKE_FIELD_W 160
`define SNAKE_FIELD_H 120

`define SNAKE_STEP 2

`define SNAKE_START_X 60
`define SNAKE_START_Y 60
`define SNAKE_INIT_LEN 4

// Body memory
`define SNAKE_DEPTH 2048
`define SNAKE_ADDR_W ($clog2(`SNAKE_DEPTH))

`define SNAKE_FOOD_X 30
`define SNAKE_FOOD_Y 30

`endif

// ==== common/snake_pkg.sv ====
package snake_pkg;

	// Playfield coordinate that is also the body memory word
	typedef struct packed
	{
		logic [7:0] x;
		logic [6:0] y;
	} pos_t;

	// One pixel write toward the display
	typedef struct packed
	{
		logic [7:0] x;
		logic [6:0] y;
	} plot_t;

	typedef enum logic [1:0]
	{
		dir_up,
		dir_down,
		dir_left,
		dir_right
	} dir_t;

	// Origin of the 3x3 block being drawn
	typedef enum logic [1:0]
	{
		plot_none,
		plot_stored,
		plot_curr,
		plot_food
	} plot_src_t;

	typedef enum logic [3:0]
	{
		st_init_write,
		st_init_draw,
		st_idle,
		st_move,
		st_read,
		st_draw,
		st_write,
		st_food,
		st_check
	} ctrl_state_t;

endpackage

// ==== source/snake_control.sv ====
`timescale 1ns/1ps
`include "snake_settings.svh"

module snake_control (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     step,
	input  logic                     hit,
	input  logic                     eat,
	input  logic [`SNAKE_ADDR_W-1:0] addr,
	output logic                     addr_clr,
	output logic                     addr_inc,
	output logic                     wr_init,
	output logic                     wr_prev,
	output logic                     ld_head_prev,
	output logic                     ld_curr,
	output logic                     ld_curr_prev,
	output logic                     head_init,
	output logic                     head_move,
	output logic                     check_eat,
	output snake_pkg::plot_src_t     plot_src,
	output logic [3:0]               sub,
	output logic                     busy,
	output logic                     dead,
	output logic [`SNAKE_ADDR_W-1:0] length
);
	import snake_pkg::*;

	localparam logic [`SNAKE_ADDR_W-1:0] init_len = `SNAKE_INIT_LEN;
	localparam logic [`SNAKE_ADDR_W-1:0] init_last = init_len - 1'b1;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic        init_phase;
	logic        blk_last;
	logic        seg_last;
	logic        init_done;
	logic        start;

	assign blk_last = (sub == 4'd8);
	// Compared before the increment so the walk ends without a spare cycle
	assign seg_last = (addr == length - 1'b1);
	assign init_done = (state == st_init_write) && (addr == init_last);
	assign start = (state == st_idle) && step && !dead;
	assign busy = (state != st_idle);

	always_comb
	begin
		state_nxt = state;
		case (state)
			st_init_write: if (init_done) state_nxt = st_init_draw;
			st_init_draw: state_nxt = st_read;
			st_idle: if (start) state_nxt = st_move;
			st_move: state_nxt = st_write;
			st_write: state_nxt = st_read;
			st_read: state_nxt = st_draw;
			st_draw:
			begin
				if (blk_last)
				begin
					if (seg_last)
						state_nxt = st_food;
					else if (init_phase)
						state_nxt = st_init_draw;
					else
						state_nxt = st_write;
				end
			end
			st_food: if (blk_last) state_nxt = init_phase ? st_idle : st_check;
			st_check: state_nxt = st_idle;
			default: state_nxt = st_idle;
		endcase
	end

	// Head moves on the edge that takes the step
	assign head_move = start;
	assign head_init = (state == st_init_write);
	assign wr_init = (state == st_init_write);
	assign addr_clr = init_done || (state == st_move);
	assign addr_inc = ((state == st_init_write) && !init_done) || ((state == st_draw) && blk_last);
	assign wr_prev = (state == st_write);
	assign ld_head_prev = (state == st_move);
	assign ld_curr = (state == st_read);
	assign ld_curr_prev = (state == st_draw) && blk_last;
	assign check_eat = (state == st_check);

	always_comb
	begin
		if (state == st_draw)
			plot_src = init_phase ? plot_curr : plot_stored;
		else if (state == st_food)
			plot_src = plot_food;
		else
			plot_src = plot_none;
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= st_init_write;
			sub <= '0;
			init_phase <= 1'b1;
			length <= init_len;
			dead <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if ((state == st_draw || state == st_food) && !blk_last)
				sub <= sub + 1'b1;
			else
				sub <= '0;
			if (state == st_food && blk_last)
				init_phase <= 1'b0;
			if (state == st_draw && hit)
				dead <= 1'b1;
			if (eat)
				length <= length + 1'b1;
		end
	end

endmodule

// ==== source/segment_store.sv ====
`timescale 1ns/1ps
`include "snake_settings.svh"

module segment_store (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     addr_clr,
	input  logic                     addr_inc,
	input  logic                     wr_init,
	input  logic                     wr_prev,
	input  logic                     ld_head_prev,
	input  logic                     ld_curr,
	input  logic                     ld_curr_prev,
	input  snake_pkg::pos_t          head,
	output logic [`SNAKE_ADDR_W-1:0] addr,
	output snake_pkg::pos_t          stored,
	output snake_pkg::pos_t          curr,
	output logic                     hit
);
	import snake_pkg::*;

	pos_t mem [0:`SNAKE_DEPTH-1];
	pos_t prev;
	pos_t init_word;

	// Initial body is a vertical column with three rows per segment
	assign init_word.x = 8'(`SNAKE_START_X);
	assign init_word.y = 7'(`SNAKE_START_Y) + 7'(3 * addr);

	// A write on the same edge still reads back the old word
	always_ff @(posedge clk)
	begin
		if (wr_init)
			mem[addr] <= init_word;
		else if (wr_prev)
			mem[addr] <= prev;
		stored <= mem[addr];
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			addr <= '0;
			hit <= 1'b0;
		end
		else
		begin
			if (addr_clr)
				addr <= '0;
			else if (addr_inc)
				addr <= addr + 1'b1;
			// Slot 0 is the head itself
			hit <= (addr != '0) && (mem[addr] == head);
		end
	end

	always_ff @(posedge clk)
	begin
		if (ld_head_prev)
			prev <= head;
		else if (ld_curr_prev)
			prev <= curr;
		if (ld_curr)
			curr <= stored;
	end

endmodule

// ==== source/head_stepper.sv ====
`timescale 1ns/1ps
`include "snake_settings.svh"

module head_stepper (
	input  logic            clk,
	input  logic            rst,
	input  logic            head_init,
	input  logic            head_move,
	input  snake_pkg::dir_t dir,
	output snake_pkg::pos_t head
);
	import snake_pkg::*;

	localparam pos_t start_pos = '{x: 8'(`SNAKE_START_X), y: 7'(`SNAKE_START_Y)};
	// Last even coordinate that a wrap past zero lands on
	localparam logic [7:0] x_wrap = 8'(`SNAKE_FIELD_W) & ~8'd1;
	localparam logic [6:0] y_wrap = 7'(`SNAKE_FIELD_H) & ~7'd1;

	pos_t       head_nxt;
	logic [8:0] x_inc;
	logic [7:0] y_inc;

	// One extra bit so the overflow compare sees the true sum
	assign x_inc = head.x + 9'(`SNAKE_STEP);
	assign y_inc = head.y + 8'(`SNAKE_STEP);

	always_comb
	begin
		head_nxt = head;
		case (dir)
			dir_up: head_nxt.y = (head.y < 7'(`SNAKE_STEP)) ? y_wrap : head.y - 7'(`SNAKE_STEP);
			dir_down: head_nxt.y = (y_inc > 8'(`SNAKE_FIELD_H)) ? '0 : y_inc[6:0];
			dir_left: head_nxt.x = (head.x < 8'(`SNAKE_STEP)) ? x_wrap : head.x - 8'(`SNAKE_STEP);
			dir_right: head_nxt.x = (x_inc > 9'(`SNAKE_FIELD_W)) ? '0 : x_inc[7:0];
			default: head_nxt = head;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			head <= start_pos;
		else if (head_init)
			head <= start_pos;
		else if (head_move)
			head <= head_nxt;
	end

endmodule

// ==== source/food_placer.sv ====
`timescale 1ns/1ps
`include "snake_settings.svh"

module food_placer (
	input  logic            clk,
	input  logic            rst,
	input  logic            lock,
	input  logic            check_eat,
	input  snake_pkg::pos_t head,
	output snake_pkg::pos_t food,
	output logic            eat
);
	import snake_pkg::*;

	// x scan stops at 156 so an aligned block stays inside the columns
	localparam logic [7:0] scan_x_last = 8'(`SNAKE_FIELD_W - 4);
	localparam logic [6:0] scan_y_last = 7'(`SNAKE_FIELD_H);
	localparam pos_t food_start = '{x: 8'(`SNAKE_FOOD_X), y: 7'(`SNAKE_FOOD_Y)};

	logic [7:0] scan_x;
	logic [6:0] scan_y;
	pos_t       cand;

	assign eat = check_eat && (head == food);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			scan_x <= '0;
			scan_y <= '0;
			cand <= '0;
			food <= food_start;
		end
		else
		begin
			scan_x <= (scan_x == scan_x_last) ? '0 : scan_x + 1'b1;
			scan_y <= (scan_y == scan_y_last) ? '0 : scan_y + 1'b1;
			// Round down to the 3-pixel grid
			if (lock)
			begin
				cand.x <= scan_x - scan_x % 8'd3;
				cand.y <= scan_y - scan_y % 7'd3;
			end
			if (eat)
				food <= cand;
		end
	end

endmodule

// ==== source/block_plotter.sv ====
`timescale 1ns/1ps

module block_plotter (
	input  snake_pkg::plot_src_t plot_src,
	input  logic [3:0]           sub,
	input  snake_pkg::pos_t      stored,
	input  snake_pkg::pos_t      curr,
	input  snake_pkg::pos_t      food,
	output logic                 plot_en,
	output snake_pkg::plot_t     plot
);
	import snake_pkg::*;

	pos_t       origin;
	logic [3:0] col;
	logic [3:0] row;

	always_comb
	begin
		case (plot_src)
			plot_stored: origin = stored;
			plot_curr: origin = curr;
			plot_food: origin = food;
			default: origin = '0;
		endcase
	end

	// sub walks the block column by column
	assign col = sub / 4'd3;
	assign row = sub % 4'd3;

	always_comb
	begin
		plot.x = origin.x + 8'(col);
		plot.y = origin.y + 7'(row);
	end

	assign plot_en = (plot_src != plot_none);

endmodule

// ==== source/snake_top.sv ====
`timescale 1ns/1ps
`include "snake_settings.svh"

module snake_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     step,
	input  snake_pkg::dir_t          dir,
	input  logic                     lock,
	output logic                     plot_en,
	output snake_pkg::plot_t         plot,
	output logic                     dead,
	output logic                     busy,
	output logic [`SNAKE_ADDR_W-1:0] length
);
	import snake_pkg::*;

	logic                     addr_clr;
	logic                     addr_inc;
	logic                     wr_init;
	logic                     wr_prev;
	logic                     ld_head_prev;
	logic                     ld_curr;
	logic                     ld_curr_prev;
	logic                     head_init;
	logic                     head_move;
	logic                     check_eat;
	logic                     hit;
	logic                     eat;
	logic [`SNAKE_ADDR_W-1:0] addr;
	logic [3:0]               sub;
	plot_src_t                plot_src;
	pos_t                     head;
	pos_t                     stored;
	pos_t                     curr;
	pos_t                     food;

	snake_control u_control (
		.clk(clk), .rst(rst), .step(step), .hit(hit), .eat(eat), .addr(addr),
		.addr_clr(addr_clr), .addr_inc(addr_inc), .wr_init(wr_init), .wr_prev(wr_prev),
		.ld_head_prev(ld_head_prev), .ld_curr(ld_curr), .ld_curr_prev(ld_curr_prev),
		.head_init(head_init), .head_move(head_move), .check_eat(check_eat),
		.plot_src(plot_src), .sub(sub), .busy(busy), .dead(dead), .length(length)
	);

	segment_store u_store (
		.clk(clk), .rst(rst), .addr_clr(addr_clr), .addr_inc(addr_inc),
		.wr_init(wr_init), .wr_prev(wr_prev), .ld_head_prev(ld_head_prev),
		.ld_curr(ld_curr), .ld_curr_prev(ld_curr_prev), .head(head),
		.addr(addr), .stored(stored), .curr(curr), .hit(hit)
	);

	head_stepper u_head (
		.clk(clk), .rst(rst), .head_init(head_init), .head_move(head_move),
		.dir(dir), .head(head)
	);

	food_placer u_food (
		.clk(clk), .rst(rst), .lock(lock), .check_eat(check_eat), .head(head),
		.food(food), .eat(eat)
	);

	block_plotter u_plot (
		.plot_src(plot_src), .sub(sub), .stored(stored), .curr(curr), .food(food),
		.plot_en(plot_en), .plot(plot)
	);

endmodule

// ==== sim/snake_tb.sv ====
`timescale 1ns/1ps
`include "snake_settings.svh"

module snake_tb;
	import snake_pkg::*;

	typedef struct packed
	{
		dir_t       d;
		logic [7:0] reps;
		logic       lock;
		logic       rnd;
		logic       dead;
		logic       grow;
	} entry_t;

	localparam int n_rows = 9;
	localparam int init_cycles = `SNAKE_INIT_LEN + 11 * `SNAKE_INIT_LEN + 9;
	// x scan runs 0..156, y scan runs 0..120
	localparam int scan_x_span = `SNAKE_FIELD_W - 3;
	localparam int scan_y_span = `SNAKE_FIELD_H + 1;

	logic                     clk;
	logic                     rst;
	logic                     step;
	dir_t                     dir;
	logic                     lock;
	logic                     plot_en;
	plot_t                    plot;
	logic                     dead;
	logic                     busy;
	logic [`SNAKE_ADDR_W-1:0] length;

	entry_t      rows [n_rows];
	pos_t        body [$];
	plot_t       expect_q [$];
	pos_t        food_m;
	pos_t        cand_m;
	int          scan_x_m;
	int          scan_y_m;
	int          len_m;
	bit          dead_m;
	int          px_count;
	int          cycle_cnt;
	int          cycle_limit;
	logic [31:0] lfsr;

	snake_top uut (
		.clk(clk), .rst(rst), .step(step), .dir(dir), .lock(lock),
		.plot_en(plot_en), .plot(plot), .dead(dead), .busy(busy), .length(length)
	);

	always #10 clk = ~clk;

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'h8020_0003;
		return n;
	endfunction

	// Increments wrap to 0, decrements to the last even coordinate
	function automatic pos_t next_head(input pos_t h, input dir_t d);
		int   x;
		int   y;
		pos_t n;
		x = h.x;
		y = h.y;
		case (d)
			dir_up: y = (y >= `SNAKE_STEP) ? y - `SNAKE_STEP : (`SNAKE_FIELD_H / 2) * 2;
			dir_down: y = (y + `SNAKE_STEP > `SNAKE_FIELD_H) ? 0 : y + `SNAKE_STEP;
			dir_left: x = (x >= `SNAKE_STEP) ? x - `SNAKE_STEP : (`SNAKE_FIELD_W / 2) * 2;
			dir_right: x = (x + `SNAKE_STEP > `SNAKE_FIELD_W) ? 0 : x + `SNAKE_STEP;
			default: x = h.x;
		endcase
		n.x = 8'(x);
		n.y = 7'(y);
		return n;
	endfunction

	// Block pixels go column by column
	task automatic push_block(input pos_t o);
		plot_t px;
		for (int c = 0; c < 3; c++)
		begin
			for (int r = 0; r < 3; r++)
			begin
				px.x = 8'(o.x + c);
				px.y = 7'(o.y + r);
				expect_q.push_back(px);
			end
		end
	endtask

	always @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			scan_x_m = 0;
			scan_y_m = 0;
			cand_m = '0;
		end
		else
		begin
			if (lock)
			begin
				cand_m.x = 8'((scan_x_m / 3) * 3);
				cand_m.y = 7'((scan_y_m / 3) * 3);
			end
			scan_x_m = (scan_x_m + 1) % scan_x_span;
			scan_y_m = (scan_y_m + 1) % scan_y_span;
		end
	end

	always @(negedge clk)
	begin
		if (rst && plot_en)
		begin
			px_count++;
			assert (expect_q.size() > 0)
			else abort_run($sformatf("error: %0t ns, unexpected pixel (%0d, %0d)",
				$time, plot.x, plot.y));
			assert (plot == expect_q[0])
			else abort_run($sformatf("error: %0t ns, pixel (%0d, %0d), expected (%0d, %0d)",
				$time, plot.x, plot.y, expect_q[0].x, expect_q[0].y));
			void'(expect_q.pop_front());
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit)
			abort_run("The run went past its cycle limit before all tests were done");
	end

	task automatic run_step(input dir_t d, input logic lk, input logic exp_dead,
		input logic exp_grow);
		pos_t h;
		int   seg_len;
		int   cnt;
		seg_len = len_m;
		h = next_head(body[0], d);
		body.push_front(h);
		while (body.size() > seg_len)
			void'(body.pop_back());
		for (int k = 1; k < seg_len; k++)
		begin
			if (body[k] == h)
				dead_m = 1'b1;
		end
		for (int k = 0; k < seg_len; k++)
			push_block(body[k]);
		push_block(food_m);
		px_count = 0;
		dir = d;
		lock = lk;
		step = 1'b1;
		cnt = 0;
		do
		begin
			@(negedge clk);
			step = 1'b0;
			lock = 1'b0;
			cnt++;
		end
		while (busy);
		if (h == food_m)
		begin
			food_m = cand_m;
			len_m++;
		end
		assert (cnt == 11 * seg_len + 12)
		else abort_run($sformatf("error: %0t ns, step took %0d cycles, expected %0d",
			$time, cnt, 11 * seg_len + 12));
		assert (px_count == 9 * (seg_len + 1) && expect_q.size() == 0)
		else abort_run($sformatf("error: %0t ns, %0d pixels written, expected %0d",
			$time, px_count, 9 * (seg_len + 1)));
		assert (dead == dead_m && dead == exp_dead)
		else abort_run($sformatf("error: %0t ns, dead is %0b, expected %0b",
			$time, dead, exp_dead));
		assert (length == len_m && (len_m - seg_len) == exp_grow)
		else abort_run($sformatf("error: %0t ns, length is %0d, expected %0d",
			$time, length, seg_len + exp_grow));
	endtask

	// A dead snake ignores the pulse and stays idle
	task automatic ignored_step(input dir_t d);
		dir = d;
		step = 1'b1;
		repeat (11 * len_m + 12)
		begin
			@(negedge clk);
			step = 1'b0;
			assert (!busy && dead && length == len_m)
			else abort_run($sformatf("error: %0t ns, step taken after death", $time));
		end
	endtask

	initial
	begin
		int   total;
		int   len_est;
		int   cnt;
		dir_t d;
		logic b0;
		logic b1;
		pos_t p;
		clk = 1'b0;
		rst = 1'b0;
		step = 1'b0;
		dir = dir_up;
		lock = 1'b0;
		lfsr = 32'h187f_d336;
		cand_m = '0;
		cycle_cnt = 0;
		// Run left to x 30, then up onto the food
		rows[0] = '{d: dir_left, reps: 15, lock: 0, rnd: 0, dead: 0, grow: 0};
		rows[1] = '{d: dir_up, reps: 14, lock: 0, rnd: 0, dead: 0, grow: 0};
		rows[2] = '{d: dir_up, reps: 1, lock: 1, rnd: 0, dead: 0, grow: 1};
		// Wrap past each edge
		rows[3] = '{d: dir_up, reps: 16, lock: 0, rnd: 0, dead: 0, grow: 0};
		rows[4] = '{d: dir_left, reps: 16, lock: 0, rnd: 0, dead: 0, grow: 0};
		rows[5] = '{d: dir_down, reps: 1, lock: 0, rnd: 0, dead: 0, grow: 0};
		rows[6] = '{d: dir_right, reps: 1, lock: 0, rnd: 0, dead: 0, grow: 0};
		// Turn back into the neck
		rows[7] = '{d: dir_left, reps: 1, lock: 0, rnd: 0, dead: 1, grow: 0};
		rows[8] = '{d: dir_up, reps: 3, lock: 0, rnd: 1, dead: 1, grow: 0};
		total = init_cycles;
		len_est = `SNAKE_INIT_LEN;
		for (int i = 0; i < n_rows; i++)
		begin
			total += rows[i].reps * (11 * len_est + 12);
			if (rows[i].grow)
				len_est++;
		end
		cycle_limit = 2 * total;
		len_m = `SNAKE_INIT_LEN;
		dead_m = 1'b0;
		food_m.x = 8'(`SNAKE_FOOD_X);
		food_m.y = 7'(`SNAKE_FOOD_Y);
		for (int i = 0; i < `SNAKE_INIT_LEN; i++)
		begin
			p.x = 8'(`SNAKE_START_X);
			p.y = 7'(`SNAKE_START_Y + 3 * i);
			body.push_back(p);
			push_block(p);
		end
		push_block(food_m);
		px_count = 0;
		repeat (8) @(negedge clk);
		assert (!plot_en && !dead && busy && length == `SNAKE_INIT_LEN)
		else abort_run($sformatf("error: %0t ns, outputs wrong during reset", $time));
		rst = 1'b1;
		cnt = 0;
		do
		begin
			@(negedge clk);
			cnt++;
		end
		while (busy);
		assert (cnt == init_cycles && px_count == 45 && expect_q.size() == 0)
		else abort_run($sformatf("error: %0t ns, init took %0d cycles with %0d pixels",
			$time, cnt, px_count));
		for (int i = 0; i < n_rows; i++)
		begin
			for (int r = 0; r < rows[i].reps; r++)
			begin
				d = rows[i].d;
				if (rows[i].rnd)
				begin
					b0 = lfsr[0];
					lfsr = galois_step(lfsr);
					b1 = lfsr[0];
					lfsr = galois_step(lfsr);
					d = dir_t'({b1, b0});
				end
				if (dead_m)
					ignored_step(d);
				else
					run_step(d, rows[i].lock, rows[i].dead, rows[i].grow);
			end
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+common
common/snake_pkg.sv
source/snake_control.sv
source/segment_store.sv
source/head_stepper.sv
source/food_placer.sv
source/block_plotter.sv
source/snake_top.sv
sim/snake_tb.sv

// ==== Bender.yml ====
package:
  name: snake

sources:
  - include_dirs:
      - common
    files:
      - common/snake_pkg.sv
      - source/snake_control.sv
      - source/segment_store.sv
      - source/head_stepper.sv
      - source/food_placer.sv
      - source/block_plotter.sv
      - source/snake_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/snake_tb.sv
